// File: wb_ic_cfg_pkg.sv
// Interconnect bus configuration
`default_nettype none

package wb_ic_cfg_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------

  // Master side address
  localparam int ADR_W     = 32;
  // Write and read data
  localparam int DAT_W     = 32;
  // One select bit per byte lane
  localparam int SEL_W     = DAT_W / 8;
  // UART and pin-mux slaves only decode the low bits
  localparam int SLV_ADR_W = 9;

  // Slave ports behind the interconnect
  localparam int NUM_TGT   = 3;

  // ------------------------------
  // Address map
  // ------------------------------

  // Serial flash memory window, bits 31:28
  localparam logic [3:0]  MEM_TOP_NIBBLE = 4'h0;
  // Flash controller registers, bits 31:16
  localparam logic [15:0] REG_HI         = 16'h1000;
  // UART block, bits 31:16
  localparam logic [15:0] UART_HI        = 16'h1001;
  // Pin-mux and global registers, bits 31:16
  localparam logic [15:0] PMUX_HI        = 16'h1002;

endpackage

`default_nettype wire

// File: wb_ic_types_pkg.sv
// Interconnect shared types
`default_nettype none

package wb_ic_types_pkg;

  // ------------------------------
  // Target decode
  // ------------------------------

  // Slave selected by a master address
  // TGT_NONE marks a hole in the address map
  typedef enum logic [1:0] {
    TGT_SPI  = 2'd0,
    TGT_UART = 2'd1,
    TGT_PMUX = 2'd2,
    TGT_NONE = 2'd3
  } tgt_e;

  // Per slave arbiter FSM
  typedef enum logic {
    ARB_IDLE = 1'b0,
    ARB_BUSY = 1'b1
  } arb_state_e;

  // ------------------------------
  // Response path
  // ------------------------------

  // One slave's answer towards one master
  typedef struct packed {
    logic [wb_ic_cfg_pkg::DAT_W-1:0] data;
    logic                            ack;
    logic                            err;
  } wb_resp_t;

endpackage

`default_nettype wire

// File: wb_req_if.sv
// Decoded master request bundle
`timescale 1ns/1ps
`default_nettype none

interface wb_req_if;
  import wb_ic_cfg_pkg::*;
  import wb_ic_types_pkg::*;

  // Address as seen by the master
  logic [ADR_W-1:0] adr;
  // Write data
  logic [DAT_W-1:0] dat_w;
  // Byte lane enables
  logic [SEL_W-1:0] sel;
  // Write when high
  logic             we;
  // Cycle, held high to keep the bus
  logic             cyc;
  // Strobe, already gated for unmapped addresses
  logic             stb;
  // Slave picked by the address decoder
  tgt_e             tgt;

  // Master port side drives the request
  modport src (
    output adr,
    output dat_w,
    output sel,
    output we,
    output cyc,
    output stb,
    output tgt
  );

  // Slave port side only observes
  modport dst (
    input adr,
    input dat_w,
    input sel,
    input we,
    input cyc,
    input stb,
    input tgt
  );

endinterface

`default_nettype wire

// File: wb_rr_arbiter.sv
// Round-robin bus arbiter
`timescale 1ns/1ps
`default_nettype none

module wb_rr_arbiter #(
  parameter int NUM_MST = 3
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // One request per master
  input  logic [NUM_MST-1:0] req_i,
  // Owner still holds its cycle
  input  logic               hold_i,
  // Registered grant
  output logic [NUM_MST-1:0] gnt_o
);
  import wb_ic_types_pkg::*;

  localparam int IDX_W = $clog2(NUM_MST);

  arb_state_e         state_q;
  logic [NUM_MST-1:0] gnt_q;
  logic [IDX_W-1:0]   last_q;
  logic [NUM_MST-1:0] nxt_gnt;
  logic [IDX_W-1:0]   nxt_idx;
  logic               nxt_found;

  // ------------------------------
  // Next owner search
  // ------------------------------

  // Scan starts right after the last owner and wraps
  always_comb begin : p_pick
    int cand;
    nxt_gnt   = '0;
    nxt_idx   = last_q;
    nxt_found = 1'b0;
    for (int i = 1; i <= NUM_MST; i++) begin
      cand = int'(last_q) + i;
      if (cand >= NUM_MST) begin
        cand = cand - NUM_MST;
      end
      // First hit wins
      if (!nxt_found && req_i[cand]) begin
        nxt_found     = 1'b1;
        nxt_gnt[cand] = 1'b1;
        nxt_idx       = IDX_W'(cand);
      end
    end
  end

  // ------------------------------
  // Grant FSM
  // ------------------------------

  // Master 0 is first after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ARB_IDLE;
      gnt_q   <= '0;
      last_q  <= IDX_W'(NUM_MST - 1);
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (nxt_found) begin
            gnt_q   <= nxt_gnt;
            last_q  <= nxt_idx;
            state_q <= ARB_BUSY;
          end
        end
        ARB_BUSY: begin
          // Owner gave up its cycle
          if (!hold_i) begin
            gnt_q   <= '0;
            state_q <= ARB_IDLE;
          end
        end
        default: begin
          gnt_q   <= '0;
          state_q <= ARB_IDLE;
        end
      endcase
    end
  end

  assign gnt_o = gnt_q;

  // At most one owner at a time
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(gnt_o));

endmodule

`default_nettype wire

// File: wb_master_port.sv
// Master port decoder
`timescale 1ns/1ps
`default_nettype none

module wb_master_port (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  // Wishbone master side
  input  logic [wb_ic_cfg_pkg::ADR_W-1:0]   wb_adr_i,
  input  logic [wb_ic_cfg_pkg::DAT_W-1:0]   wb_dat_i,
  input  logic [wb_ic_cfg_pkg::SEL_W-1:0]   wb_sel_i,
  input  logic                              wb_we_i,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  output logic [wb_ic_cfg_pkg::DAT_W-1:0]   wb_dat_o,
  output logic                              wb_ack_o,
  output logic                              wb_err_o,
  // Decoded request towards all slave ports
  wb_req_if.src                             req,
  // One answer per slave port
  input  wb_ic_types_pkg::wb_resp_t         resp_i [wb_ic_cfg_pkg::NUM_TGT]
);
  import wb_ic_cfg_pkg::*;
  import wb_ic_types_pkg::*;

  tgt_e     tgt;
  wb_resp_t resp_sel;
  logic     unmapped;
  logic     err_q;

  // ------------------------------
  // Address decode
  // ------------------------------

  // Flash memory and flash registers share slave 0
  always_comb begin
    if (wb_adr_i[31:28] == MEM_TOP_NIBBLE) begin
      tgt = TGT_SPI;
    end else if (wb_adr_i[31:16] == REG_HI) begin
      tgt = TGT_SPI;
    end else if (wb_adr_i[31:16] == UART_HI) begin
      tgt = TGT_UART;
    end else if (wb_adr_i[31:16] == PMUX_HI) begin
      tgt = TGT_PMUX;
    end else begin
      tgt = TGT_NONE;
    end
  end

  assign unmapped  = (tgt == TGT_NONE);

  // Request fan-out, no slave sees a strobe for a hole
  assign req.adr   = wb_adr_i;
  assign req.dat_w = wb_dat_i;
  assign req.sel   = wb_sel_i;
  assign req.we    = wb_we_i;
  assign req.cyc   = wb_cyc_i;
  assign req.stb   = wb_stb_i & ~unmapped;
  assign req.tgt   = tgt;

  // ------------------------------
  // Unmapped error
  // ------------------------------

  // Raised one cycle after the strobe, held while the strobe stays up
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= wb_cyc_i & wb_stb_i & unmapped;
    end
  end

  // Response select, follows the same decode as the request
  always_comb begin
    case (tgt)
      TGT_SPI:  resp_sel = resp_i[TGT_SPI];
      TGT_UART: resp_sel = resp_i[TGT_UART];
      TGT_PMUX: resp_sel = resp_i[TGT_PMUX];
      default:  resp_sel = '0;
    endcase
  end

  assign wb_dat_o = resp_sel.data;
  assign wb_ack_o = resp_sel.ack;
  assign wb_err_o = resp_sel.err | (err_q & wb_stb_i);

  // A transfer ends with exactly one of ack or err
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(wb_ack_o && wb_err_o));

endmodule

`default_nettype wire

// File: wb_slave_port.sv
// Slave port with arbitration
`timescale 1ns/1ps
`default_nettype none

module wb_slave_port #(
  parameter int                    NUM_MST   = 3,
  parameter wb_ic_types_pkg::tgt_e TARGET_ID = wb_ic_types_pkg::TGT_SPI
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  // Decoded requests of every master
  wb_req_if.dst                           mst [NUM_MST],
  // Wishbone slave side
  output logic [wb_ic_cfg_pkg::ADR_W-1:0] s_adr_o,
  output logic [wb_ic_cfg_pkg::DAT_W-1:0] s_dat_o,
  output logic [wb_ic_cfg_pkg::SEL_W-1:0] s_sel_o,
  output logic                            s_we_o,
  output logic                            s_cyc_o,
  output logic                            s_stb_o,
  input  logic [wb_ic_cfg_pkg::DAT_W-1:0] s_dat_i,
  input  logic                            s_ack_i,
  // Answer towards each master
  output wb_ic_types_pkg::wb_resp_t       resp_o [NUM_MST]
);
  import wb_ic_cfg_pkg::*;

  logic [NUM_MST-1:0] req_vec;
  logic [NUM_MST-1:0] stb_vec;
  logic [NUM_MST-1:0] we_vec;
  logic [NUM_MST-1:0] gnt;
  logic               hold;
  logic [ADR_W-1:0]   adr_a [NUM_MST];
  logic [DAT_W-1:0]   dat_a [NUM_MST];
  logic [SEL_W-1:0]   sel_a [NUM_MST];

  // ------------------------------
  // Per master request and reply
  // ------------------------------

  for (genvar i = 0; i < NUM_MST; i++) begin : g_mst
    // Only masters aimed at this slave compete
    assign req_vec[i] = mst[i].cyc & (mst[i].tgt == TARGET_ID);
    assign stb_vec[i] = mst[i].stb;
    assign we_vec[i]  = mst[i].we;
    assign adr_a[i]   = mst[i].adr;
    assign dat_a[i]   = mst[i].dat_w;
    assign sel_a[i]   = mst[i].sel;

    // Read data and ack go to the owner only
    assign resp_o[i] = '{
      data: gnt[i] ? s_dat_i : '0,
      ack:  gnt[i] & s_ack_i,
      err:  1'b0
    };
  end

  // Owner keeps the bus as long as its cycle stays on this slave
  assign hold = |(gnt & req_vec);

  wb_rr_arbiter #(
    .NUM_MST (NUM_MST)
  ) u_arb (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_vec),
    .hold_i   (hold),
    .gnt_o    (gnt)
  );

  // ------------------------------
  // Request mux
  // ------------------------------

  // AND-OR select on the one-hot grant
  always_comb begin
    s_adr_o = '0;
    s_dat_o = '0;
    s_sel_o = '0;
    s_we_o  = 1'b0;
    for (int i = 0; i < NUM_MST; i++) begin
      if (gnt[i]) begin
        s_adr_o = s_adr_o | adr_a[i];
        s_dat_o = s_dat_o | dat_a[i];
        s_sel_o = s_sel_o | sel_a[i];
        s_we_o  = s_we_o | we_vec[i];
      end
    end
  end

  // Cycle and strobe only while the owner still targets this slave
  assign s_cyc_o = |(gnt & req_vec);
  assign s_stb_o = |(gnt & req_vec & stb_vec);

  // Strobe never shows up outside a cycle
  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s_stb_o |-> s_cyc_o);

endmodule

`default_nettype wire

// File: wb_interconnect.sv
// Shared bus Wishbone interconnect
`timescale 1ns/1ps
`default_nettype none

module wb_interconnect (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // Master 0
  input  logic [wb_ic_cfg_pkg::DAT_W-1:0]     m0_wbd_dat_i,
  input  logic [wb_ic_cfg_pkg::ADR_W-1:0]     m0_wbd_adr_i,
  input  logic [wb_ic_cfg_pkg::SEL_W-1:0]     m0_wbd_sel_i,
  input  logic                                m0_wbd_we_i,
  input  logic                                m0_wbd_cyc_i,
  input  logic                                m0_wbd_stb_i,
  output logic [wb_ic_cfg_pkg::DAT_W-1:0]     m0_wbd_dat_o,
  output logic                                m0_wbd_ack_o,
  output logic                                m0_wbd_err_o,
  // Master 1
  input  logic [wb_ic_cfg_pkg::DAT_W-1:0]     m1_wbd_dat_i,
  input  logic [wb_ic_cfg_pkg::ADR_W-1:0]     m1_wbd_adr_i,
  input  logic [wb_ic_cfg_pkg::SEL_W-1:0]     m1_wbd_sel_i,
  input  logic                                m1_wbd_we_i,
  input  logic                                m1_wbd_cyc_i,
  input  logic                                m1_wbd_stb_i,
  output logic [wb_ic_cfg_pkg::DAT_W-1:0]     m1_wbd_dat_o,
  output logic                                m1_wbd_ack_o,
  output logic                                m1_wbd_err_o,
  // Master 2
  input  logic [wb_ic_cfg_pkg::DAT_W-1:0]     m2_wbd_dat_i,
  input  logic [wb_ic_cfg_pkg::ADR_W-1:0]     m2_wbd_adr_i,
  input  logic [wb_ic_cfg_pkg::SEL_W-1:0]     m2_wbd_sel_i,
  input  logic                                m2_wbd_we_i,
  input  logic                                m2_wbd_cyc_i,
  input  logic                                m2_wbd_stb_i,
  output logic [wb_ic_cfg_pkg::DAT_W-1:0]     m2_wbd_dat_o,
  output logic                                m2_wbd_ack_o,
  output logic                                m2_wbd_err_o,
  // Slave 0, flash memory and its registers
  input  logic [wb_ic_cfg_pkg::DAT_W-1:0]     s0_wbd_dat_i,
  input  logic                                s0_wbd_ack_i,
  output logic [wb_ic_cfg_pkg::DAT_W-1:0]     s0_wbd_dat_o,
  output logic [wb_ic_cfg_pkg::ADR_W-1:0]     s0_wbd_adr_o,
  output logic [wb_ic_cfg_pkg::SEL_W-1:0]     s0_wbd_sel_o,
  output logic                                s0_wbd_we_o,
  output logic                                s0_wbd_cyc_o,
  output logic                                s0_wbd_stb_o,
  // Slave 1, UART
  input  logic [wb_ic_cfg_pkg::DAT_W-1:0]     s1_wbd_dat_i,
  input  logic                                s1_wbd_ack_i,
  output logic [wb_ic_cfg_pkg::DAT_W-1:0]     s1_wbd_dat_o,
  output logic [wb_ic_cfg_pkg::SLV_ADR_W-1:0] s1_wbd_adr_o,
  output logic [wb_ic_cfg_pkg::SEL_W-1:0]     s1_wbd_sel_o,
  output logic                                s1_wbd_we_o,
  output logic                                s1_wbd_cyc_o,
  output logic                                s1_wbd_stb_o,
  // Slave 2, pin-mux and global registers
  input  logic [wb_ic_cfg_pkg::DAT_W-1:0]     s2_wbd_dat_i,
  input  logic                                s2_wbd_ack_i,
  output logic [wb_ic_cfg_pkg::DAT_W-1:0]     s2_wbd_dat_o,
  output logic [wb_ic_cfg_pkg::SLV_ADR_W-1:0] s2_wbd_adr_o,
  output logic [wb_ic_cfg_pkg::SEL_W-1:0]     s2_wbd_sel_o,
  output logic                                s2_wbd_we_o,
  output logic                                s2_wbd_cyc_o,
  output logic                                s2_wbd_stb_o
);
  import wb_ic_cfg_pkg::*;
  import wb_ic_types_pkg::*;

  localparam int NUM_MST = 3;

  // Response arrays, by target then by master
  wb_resp_t         resp_tm [NUM_TGT][NUM_MST];
  wb_resp_t         resp_mt [NUM_MST][NUM_TGT];
  // Full width slave addresses before truncation
  logic [ADR_W-1:0] s1_adr_full;
  logic [ADR_W-1:0] s2_adr_full;

  wb_req_if req_if [NUM_MST] ();

  // Transpose so each master sees one answer per target
  for (genvar m = 0; m < NUM_MST; m++) begin : g_resp_m
    for (genvar t = 0; t < NUM_TGT; t++) begin : g_resp_t
      assign resp_mt[m][t] = resp_tm[t][m];
    end
  end

  // ------------------------------
  // Master ports
  // ------------------------------

  wb_master_port u_m0 (
    .clk_i (clk_i), .arst_n_i (arst_n_i),
    .wb_adr_i (m0_wbd_adr_i), .wb_dat_i (m0_wbd_dat_i), .wb_sel_i (m0_wbd_sel_i),
    .wb_we_i (m0_wbd_we_i), .wb_cyc_i (m0_wbd_cyc_i), .wb_stb_i (m0_wbd_stb_i),
    .wb_dat_o (m0_wbd_dat_o), .wb_ack_o (m0_wbd_ack_o), .wb_err_o (m0_wbd_err_o),
    .req (req_if[0]), .resp_i (resp_mt[0])
  );

  wb_master_port u_m1 (
    .clk_i (clk_i), .arst_n_i (arst_n_i),
    .wb_adr_i (m1_wbd_adr_i), .wb_dat_i (m1_wbd_dat_i), .wb_sel_i (m1_wbd_sel_i),
    .wb_we_i (m1_wbd_we_i), .wb_cyc_i (m1_wbd_cyc_i), .wb_stb_i (m1_wbd_stb_i),
    .wb_dat_o (m1_wbd_dat_o), .wb_ack_o (m1_wbd_ack_o), .wb_err_o (m1_wbd_err_o),
    .req (req_if[1]), .resp_i (resp_mt[1])
  );

  wb_master_port u_m2 (
    .clk_i (clk_i), .arst_n_i (arst_n_i),
    .wb_adr_i (m2_wbd_adr_i), .wb_dat_i (m2_wbd_dat_i), .wb_sel_i (m2_wbd_sel_i),
    .wb_we_i (m2_wbd_we_i), .wb_cyc_i (m2_wbd_cyc_i), .wb_stb_i (m2_wbd_stb_i),
    .wb_dat_o (m2_wbd_dat_o), .wb_ack_o (m2_wbd_ack_o), .wb_err_o (m2_wbd_err_o),
    .req (req_if[2]), .resp_i (resp_mt[2])
  );

  // ------------------------------
  // Slave ports
  // ------------------------------

  wb_slave_port #(.NUM_MST (NUM_MST), .TARGET_ID (TGT_SPI)) u_s0 (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .mst (req_if),
    .s_adr_o (s0_wbd_adr_o), .s_dat_o (s0_wbd_dat_o), .s_sel_o (s0_wbd_sel_o),
    .s_we_o (s0_wbd_we_o), .s_cyc_o (s0_wbd_cyc_o), .s_stb_o (s0_wbd_stb_o),
    .s_dat_i (s0_wbd_dat_i), .s_ack_i (s0_wbd_ack_i), .resp_o (resp_tm[TGT_SPI])
  );

  wb_slave_port #(.NUM_MST (NUM_MST), .TARGET_ID (TGT_UART)) u_s1 (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .mst (req_if),
    .s_adr_o (s1_adr_full), .s_dat_o (s1_wbd_dat_o), .s_sel_o (s1_wbd_sel_o),
    .s_we_o (s1_wbd_we_o), .s_cyc_o (s1_wbd_cyc_o), .s_stb_o (s1_wbd_stb_o),
    .s_dat_i (s1_wbd_dat_i), .s_ack_i (s1_wbd_ack_i), .resp_o (resp_tm[TGT_UART])
  );

  wb_slave_port #(.NUM_MST (NUM_MST), .TARGET_ID (TGT_PMUX)) u_s2 (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .mst (req_if),
    .s_adr_o (s2_adr_full), .s_dat_o (s2_wbd_dat_o), .s_sel_o (s2_wbd_sel_o),
    .s_we_o (s2_wbd_we_o), .s_cyc_o (s2_wbd_cyc_o), .s_stb_o (s2_wbd_stb_o),
    .s_dat_i (s2_wbd_dat_i), .s_ack_i (s2_wbd_ack_i), .resp_o (resp_tm[TGT_PMUX])
  );

  // UART and pin-mux decode only the low address bits
  assign s1_wbd_adr_o = s1_adr_full[SLV_ADR_W-1:0];
  assign s2_wbd_adr_o = s2_adr_full[SLV_ADR_W-1:0];

endmodule

`default_nettype wire

// File: tb_wb_slave_model.sv
// Behavioral Wishbone slave
`timescale 1ns/1ps
`default_nettype none

module tb_wb_slave_model #(
  parameter int AW     = 32,
  parameter int SLV_ID = 0
) (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic [AW-1:0] adr_i,
  input  logic [31:0]   dat_i,
  input  logic [3:0]    sel_i,
  input  logic          we_i,
  input  logic          cyc_i,
  input  logic          stb_i,
  output logic [31:0]   dat_o,
  output logic          ack_o
);

  // Stored words by slave address
  logic [31:0]   mem [logic [AW-1:0]];
  // Access log, read by the testbench
  int            access_cnt = 0;
  logic [31:0]   last_adr   = '0;
  logic [3:0]    last_sel   = '0;
  int            proto_err  = 0;
  // Transfer in progress
  logic          active;
  int            wait_cnt;
  logic [AW-1:0] cur_adr;
  logic          cur_we;

  // Unwritten words read back a pattern of the whole address
  function automatic logic [31:0] fill_word(input logic [AW-1:0] adr);
    return 32'(adr) ^ 32'hC3A5_0000 ^ (32'(SLV_ID) << 24);
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_o    <= 1'b0;
      dat_o    <= '0;
      active   = 1'b0;
      wait_cnt = 0;
    end else if (ack_o) begin
      // Single cycle ack, master drops its strobe now
      ack_o <= 1'b0;
    end else if (cyc_i && stb_i) begin
      if (!active) begin
        // New transfer, pick 0 to 3 wait states
        active   = 1'b1;
        wait_cnt = $urandom_range(3, 0);
        cur_adr  = adr_i;
        cur_we   = we_i;
      end else begin
        // Request must stay put until the ack
        assert (adr_i == cur_adr && we_i == cur_we) else begin
          proto_err++;
          $display("Slave %0d saw its request change inside a held cycle at %0t",
                   SLV_ID, $time);
        end
      end
      if (wait_cnt == 0) begin
        ack_o  <= 1'b1;
        active = 1'b0;
        if (we_i) begin
          mem[adr_i] = dat_i;
        end else if (mem.exists(adr_i)) begin
          dat_o <= mem[adr_i];
        end else begin
          dat_o <= fill_word(adr_i);
        end
        access_cnt++;
        last_adr = 32'(adr_i);
        last_sel = sel_i;
      end else begin
        wait_cnt--;
      end
    end else begin
      active = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: tb_wb_interconnect.sv
// Interconnect testbench
`timescale 1ns/1ps
`default_nettype none

module tb_wb_interconnect;

  localparam int TIMEOUT = 200;
  localparam int ROUNDS  = 4;

  // One test address per region, masters add their own offset
  localparam logic [31:0] REGION_ADR [4] = '{
    32'h0012_3400,
    32'h1000_0020,
    32'h1001_3E10,
    32'h1002_A104
  };

  logic clk_i;
  logic arst_n_i;

  // ------------------------------
  // Master and slave buses
  // ------------------------------

  // Index is the master number
  logic [2:0][31:0] m_adr;
  logic [2:0][31:0] m_wdat;
  logic [2:0][3:0]  m_sel;
  logic [2:0]       m_we;
  logic [2:0]       m_cyc;
  logic [2:0]       m_stb;
  wire  [2:0][31:0] m_rdat;
  wire  [2:0]       m_ack;
  wire  [2:0]       m_err;

  // Index is the slave number
  wire  [31:0]      s0_adr;
  wire  [8:0]       s1_adr;
  wire  [8:0]       s2_adr;
  wire  [2:0][31:0] s_wdat;
  wire  [2:0][31:0] s_rdat;
  wire  [2:0][3:0]  s_sel;
  wire  [2:0]       s_we;
  wire  [2:0]       s_cyc;
  wire  [2:0]       s_stb;
  wire  [2:0]       s_ack;

  int          errors;
  int          checks;
  logic        parallel_seen;
  // Expected contents, keyed by slave number and slave address
  logic [31:0] shadow [logic [33:0]];
  // Master numbers in the order their transfers completed
  int          served_q [$];

  always #10 clk_i = ~clk_i;

  wb_interconnect UUT (
    .clk_i (clk_i), .arst_n_i (arst_n_i),
    .m0_wbd_dat_i (m_wdat[0]), .m0_wbd_adr_i (m_adr[0]), .m0_wbd_sel_i (m_sel[0]),
    .m0_wbd_we_i (m_we[0]), .m0_wbd_cyc_i (m_cyc[0]), .m0_wbd_stb_i (m_stb[0]),
    .m0_wbd_dat_o (m_rdat[0]), .m0_wbd_ack_o (m_ack[0]), .m0_wbd_err_o (m_err[0]),
    .m1_wbd_dat_i (m_wdat[1]), .m1_wbd_adr_i (m_adr[1]), .m1_wbd_sel_i (m_sel[1]),
    .m1_wbd_we_i (m_we[1]), .m1_wbd_cyc_i (m_cyc[1]), .m1_wbd_stb_i (m_stb[1]),
    .m1_wbd_dat_o (m_rdat[1]), .m1_wbd_ack_o (m_ack[1]), .m1_wbd_err_o (m_err[1]),
    .m2_wbd_dat_i (m_wdat[2]), .m2_wbd_adr_i (m_adr[2]), .m2_wbd_sel_i (m_sel[2]),
    .m2_wbd_we_i (m_we[2]), .m2_wbd_cyc_i (m_cyc[2]), .m2_wbd_stb_i (m_stb[2]),
    .m2_wbd_dat_o (m_rdat[2]), .m2_wbd_ack_o (m_ack[2]), .m2_wbd_err_o (m_err[2]),
    .s0_wbd_dat_i (s_rdat[0]), .s0_wbd_ack_i (s_ack[0]), .s0_wbd_dat_o (s_wdat[0]),
    .s0_wbd_adr_o (s0_adr), .s0_wbd_sel_o (s_sel[0]), .s0_wbd_we_o (s_we[0]),
    .s0_wbd_cyc_o (s_cyc[0]), .s0_wbd_stb_o (s_stb[0]),
    .s1_wbd_dat_i (s_rdat[1]), .s1_wbd_ack_i (s_ack[1]), .s1_wbd_dat_o (s_wdat[1]),
    .s1_wbd_adr_o (s1_adr), .s1_wbd_sel_o (s_sel[1]), .s1_wbd_we_o (s_we[1]),
    .s1_wbd_cyc_o (s_cyc[1]), .s1_wbd_stb_o (s_stb[1]),
    .s2_wbd_dat_i (s_rdat[2]), .s2_wbd_ack_i (s_ack[2]), .s2_wbd_dat_o (s_wdat[2]),
    .s2_wbd_adr_o (s2_adr), .s2_wbd_sel_o (s_sel[2]), .s2_wbd_we_o (s_we[2]),
    .s2_wbd_cyc_o (s_cyc[2]), .s2_wbd_stb_o (s_stb[2])
  );

  tb_wb_slave_model #(.AW (32), .SLV_ID (0)) u_slv0 (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .adr_i (s0_adr), .dat_i (s_wdat[0]),
    .sel_i (s_sel[0]), .we_i (s_we[0]), .cyc_i (s_cyc[0]), .stb_i (s_stb[0]),
    .dat_o (s_rdat[0]), .ack_o (s_ack[0])
  );

  tb_wb_slave_model #(.AW (9), .SLV_ID (1)) u_slv1 (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .adr_i (s1_adr), .dat_i (s_wdat[1]),
    .sel_i (s_sel[1]), .we_i (s_we[1]), .cyc_i (s_cyc[1]), .stb_i (s_stb[1]),
    .dat_o (s_rdat[1]), .ack_o (s_ack[1])
  );

  tb_wb_slave_model #(.AW (9), .SLV_ID (2)) u_slv2 (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .adr_i (s2_adr), .dat_i (s_wdat[2]),
    .sel_i (s_sel[2]), .we_i (s_we[2]), .cyc_i (s_cyc[2]), .stb_i (s_stb[2]),
    .dat_o (s_rdat[2]), .ack_o (s_ack[2])
  );

  // ------------------------------
  // Reference model
  // ------------------------------

  // Expected slave for an address, -1 for a hole in the map
  function automatic int expect_slave(input logic [31:0] adr);
    if (adr[31:28] == 4'h0) begin
      return 0;
    end else if (adr[31:16] == 16'h1000) begin
      return 0;
    end else if (adr[31:16] == 16'h1001) begin
      return 1;
    end else if (adr[31:16] == 16'h1002) begin
      return 2;
    end
    return -1;
  endfunction

  // Slaves 1 and 2 only see the low 9 bits
  function automatic logic [31:0] expect_slave_adr(input int s, input logic [31:0] adr);
    return (s == 0) ? adr : {23'h0, adr[8:0]};
  endfunction

  function automatic logic [33:0] shadow_key(input int s, input logic [31:0] slv_adr);
    return {2'(s), slv_adr};
  endfunction

  function automatic int slave_count(input int s);
    case (s)
      0:       return u_slv0.access_cnt;
      1:       return u_slv1.access_cnt;
      default: return u_slv2.access_cnt;
    endcase
  endfunction

  function automatic logic [31:0] slave_last_adr(input int s);
    case (s)
      0:       return u_slv0.last_adr;
      1:       return u_slv1.last_adr;
      default: return u_slv2.last_adr;
    endcase
  endfunction

  function automatic logic [3:0] slave_last_sel(input int s);
    case (s)
      0:       return u_slv0.last_sel;
      1:       return u_slv1.last_sel;
      default: return u_slv2.last_sel;
    endcase
  endfunction

  // ------------------------------
  // Checks and reporting
  // ------------------------------

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  task automatic finish_run();
    int proto;
    proto = u_slv0.proto_err + u_slv1.proto_err + u_slv2.proto_err;
    $display("Checks: %0d, errors: %0d, slave protocol errors: %0d", checks, errors, proto);
    if (errors == 0 && proto == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // Idle bus, no responses and no slave cycles
  task automatic check_idle();
    for (int i = 0; i < 3; i++) begin
      check_value($sformatf("m%0d_wbd_ack_o", i), m_ack[i], 1'b0);
      check_value($sformatf("m%0d_wbd_err_o", i), m_err[i], 1'b0);
      check_value($sformatf("s%0d_wbd_cyc_o", i), s_cyc[i], 1'b0);
      check_value($sformatf("s%0d_wbd_stb_o", i), s_stb[i], 1'b0);
    end
  endtask

  // Ack and err never together on any master
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      for (int i = 0; i < 3; i++) begin
        assert (!(m_ack[i] && m_err[i])) else begin
          errors++;
          $display("Master %0d got ack and err in the same cycle at %0t", i, $time);
        end
      end
    end
  end

  // All three slaves busy at once
  always @(negedge clk_i) begin
    if (&s_cyc) begin
      parallel_seen = 1'b1;
    end
  end

  // ------------------------------
  // Master drivers
  // ------------------------------

  // One transfer, driven and sampled on falling edges
  task automatic bus_access(input int m, input logic [31:0] adr, input logic we,
                            input logic [31:0] wdat, input logic [3:0] sel,
                            output logic [31:0] rdat, output logic ack,
                            output logic err);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    m_adr[m]  = adr;
    m_wdat[m] = wdat;
    m_sel[m]  = sel;
    m_we[m]   = we;
    m_cyc[m]  = 1'b1;
    m_stb[m]  = 1'b1;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!(m_ack[m] || m_err[m]) && cycles < TIMEOUT);
    rdat = m_rdat[m];
    ack  = m_ack[m];
    err  = m_err[m];
    // Drop strobe and release the bus
    m_cyc[m] = 1'b0;
    m_stb[m] = 1'b0;
    m_we[m]  = 1'b0;
    if (!(ack || err)) begin
      errors++;
      $display("Timeout: master %0d saw neither ack nor err for address %h in %0d cycles",
               m, adr, TIMEOUT);
      finish_run();
    end else if (ack) begin
      served_q.push_back(m);
    end
  endtask

  // Transfer plus comparison against the reference, solo adds slave log checks
  task automatic check_access(input int m, input logic [31:0] adr, input logic we,
                              input bit solo);
    int          exp_s;
    int          cnt_before [3];
    logic [31:0] wdat;
    logic [31:0] rdat;
    logic [31:0] slv_adr;
    logic [33:0] key;
    logic [3:0]  sel;
    logic        ack;
    logic        err;
    exp_s = expect_slave(adr);
    wdat  = $urandom();
    // Writes use every lane, reads any nonzero lane mask
    sel   = we ? 4'hF : 4'($urandom_range(15, 1));
    for (int s = 0; s < 3; s++) begin
      cnt_before[s] = slave_count(s);
    end
    bus_access(m, adr, we, wdat, sel, rdat, ack, err);
    if (exp_s < 0) begin
      check_value($sformatf("m%0d_wbd_err_o", m), err, 1'b1);
      check_value($sformatf("m%0d_wbd_ack_o", m), ack, 1'b0);
    end else begin
      slv_adr = expect_slave_adr(exp_s, adr);
      key     = shadow_key(exp_s, slv_adr);
      check_value($sformatf("m%0d_wbd_ack_o", m), ack, 1'b1);
      check_value($sformatf("m%0d_wbd_err_o", m), err, 1'b0);
      if (we) begin
        shadow[key] = wdat;
      end else if (shadow.exists(key)) begin
        check_value($sformatf("m%0d_wbd_dat_o", m), rdat, shadow[key]);
      end else begin
        errors++;
        $display("Read of address %h has no earlier write to compare with", adr);
      end
      if (solo) begin
        check_value($sformatf("s%0d_wbd_adr_o", exp_s), slave_last_adr(exp_s), slv_adr);
        check_value($sformatf("s%0d_wbd_sel_o", exp_s), slave_last_sel(exp_s), sel);
      end
    end
    // Only the named slave logs the access
    if (solo) begin
      for (int s = 0; s < 3; s++) begin
        check_value($sformatf("s%0d access count", s), slave_count(s),
                    cnt_before[s] + ((s == exp_s) ? 1 : 0));
      end
    end
  endtask

  task automatic run_rounds(input int m, input logic [31:0] base, input logic we);
    for (int r = 0; r < ROUNDS; r++) begin
      check_access(m, base + m * 32'h40 + r * 4, we, 1'b0);
    end
  endtask

  // Masters in the mask hit one slave at the same time
  task automatic contend(input logic [2:0] mask, input int s, input logic [31:0] base,
                         input logic we);
    int cnt_before;
    cnt_before = slave_count(s);
    served_q.delete();
    for (int m = 0; m < 3; m++) begin
      automatic int mm = m;
      if (mask[mm]) begin
        fork
          run_rounds(mm, base, we);
        join_none
      end
    end
    wait fork;
    check_value($sformatf("s%0d access count", s), slave_count(s),
                cnt_before + $countones(mask) * ROUNDS);
  endtask

  // No waiting master is passed over twice
  task automatic check_fairness(input logic [2:0] mask);
    int served [3];
    int lo;
    int hi;
    served = '{0, 0, 0};
    foreach (served_q[i]) begin
      served[served_q[i]]++;
      lo = 1 << 30;
      hi = 0;
      for (int m = 0; m < 3; m++) begin
        if (mask[m]) begin
          lo = (served[m] < lo) ? served[m] : lo;
          hi = (served[m] > hi) ? served[m] : hi;
        end
      end
      checks++;
      assert (hi - lo <= 1) else begin
        errors++;
        $display("Master %0d was served twice while another master waited, entry %0d",
                 served_q[i], i);
      end
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'h0c40_c82c));
    errors        = 0;
    checks        = 0;
    parallel_seen = 1'b0;
    clk_i         = 1'b0;
    arst_n_i      = 1'b0;
    m_adr         = '0;
    m_wdat        = '0;
    m_sel         = '0;
    m_we          = '0;
    m_cyc         = '0;
    m_stb         = '0;

    // Quiet bus during and after reset
    repeat (4) begin
      @(negedge clk_i);
      check_idle();
    end
    arst_n_i = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      check_idle();
    end

    // Every master, every region, write then read back
    for (int m = 0; m < 3; m++) begin
      for (int r = 0; r < 4; r++) begin
        check_access(m, REGION_ADR[r] + m * 16, 1'b1, 1'b1);
        check_access(m, REGION_ADR[r] + m * 16, 1'b0, 1'b1);
      end
    end

    // Holes in the map answer with err
    for (int m = 0; m < 3; m++) begin
      check_access(m, 32'h2000_0000 + m * 4, 1'b1, 1'b1);
      check_access(m, 32'h1003_0000, 1'b0, 1'b1);
      check_access(m, 32'hFFFF_FFF0, 1'b1, 1'b1);
    end

    // Contention on one slave
    contend(3'b111, 0, 32'h0040_0000, 1'b1);
    check_fairness(3'b111);
    contend(3'b111, 0, 32'h0040_0000, 1'b0);
    check_fairness(3'b111);
    contend(3'b101, 1, 32'h1001_0000, 1'b1);
    check_fairness(3'b101);
    contend(3'b011, 2, 32'h1002_0000, 1'b1);
    check_fairness(3'b011);
    contend(3'b101, 1, 32'h1001_0000, 1'b0);
    check_fairness(3'b101);

    // Separate slaves serve all masters in parallel
    parallel_seen = 1'b0;
    fork
      begin
        run_rounds(0, 32'h0080_0000, 1'b1);
        run_rounds(0, 32'h0080_0000, 1'b0);
      end
      begin
        run_rounds(1, 32'h1001_0100, 1'b1);
        run_rounds(1, 32'h1001_0100, 1'b0);
      end
      begin
        run_rounds(2, 32'h1002_0100, 1'b1);
        run_rounds(2, 32'h1002_0100, 1'b0);
      end
    join
    checks++;
    assert (parallel_seen) else begin
      errors++;
      $display("The three slaves never carried cycles at the same time");
    end

    finish_run();
  end

endmodule

`default_nettype wire

// File: compile.f
wb_ic_cfg_pkg.sv
wb_ic_types_pkg.sv
wb_req_if.sv
wb_rr_arbiter.sv
wb_master_port.sv
wb_slave_port.sv
wb_interconnect.sv
tb_wb_slave_model.sv
tb_wb_interconnect.sv
